/* lcd_bus_monitor.sv */
module lcd_bus_monitor
	import lcd_pkg::*;
(
	input logic      clk,
	input lcd_pins_t pins
);
	timeunit 1ns;
	timeprecision 100ps;

	// display model, every field indexed by e pulse
	lcd_cmd_t cmd_q[$];      // what the display latches at the fall of e
	lcd_cmd_t rise_cmd_q[$]; // rs, rw and data seen when e rises
	int       width_q[$];    // e high time in cycles
	int       gap_q[$];      // cycles since the previous rise, 0 for the first one

	int       cycle     = 0;
	int       last_rise = -1;
	int       high_cnt  = 0;
	logic     e_q       = 1'b0;
	lcd_cmd_t pin_cmd;
	lcd_cmd_t held_cmd;

	// sampled mid-cycle, pins settle after the rising edge
	always @(negedge clk) begin
		pin_cmd.rs   = pins.rs;
		pin_cmd.rw   = pins.rw;
		pin_cmd.data = pins.data;
		cycle++;

		if (pins.e && !e_q) begin
			gap_q.push_back(last_rise < 0 ? 0 : cycle - last_rise);
			rise_cmd_q.push_back(pin_cmd);
			last_rise = cycle;
			high_cnt  = 0;
		end

		if (pins.e) begin
			high_cnt++;
			held_cmd = pin_cmd; // last value before the fall
		end else if (e_q) begin
			cmd_q.push_back(held_cmd);
			width_q.push_back(high_cnt);
		end

		e_q = pins.e;
	end

endmodule

/* lcd_controller.sv */
module lcd_controller
	import lcd_pkg::*;
#(
	parameter int clk_mhz = 20 // clock cycles per microsecond
) (
	input  logic      clk,
	input  logic      arst_n,
	input  lcd_cfg_t  cfg,
	input  logic      lcd_enable,
	input  lcd_cmd_t  lcd_bus,
	output lcd_pins_t pins,
	output logic      busy
);

	// power-up wait in cycles
	localparam int powerup_cycles = t_powerup_us * clk_mhz;

	// init sequence windows, each value is the cycle where a phase ends
	localparam int cmd_cycles = t_cmd_us * clk_mhz;
	localparam int fs_e_end   = cmd_cycles;                                 // function set, e high
	localparam int fs_end     = fs_e_end + t_wait_short_us * clk_mhz;
	localparam int dc_e_end   = fs_end + cmd_cycles;                        // display control
	localparam int dc_end     = dc_e_end + t_wait_short_us * clk_mhz;
	localparam int clr_e_end  = dc_end + cmd_cycles;                        // clear display
	localparam int clr_end    = clr_e_end + t_wait_clear_us * clk_mhz;
	localparam int em_e_end   = clr_end + cmd_cycles;                       // entry mode
	localparam int init_end   = em_e_end + t_wait_entry_us * clk_mhz;

	// write cycle windows, counted from the first cycle of the write state
	localparam int setup_cycles = t_setup_us * clk_mhz;
	localparam int e_high_end   = setup_cycles + t_e_high_us * clk_mhz;
	// the accept cycle counts as the first cycle of the write
	localparam int write_last   = t_cycle_us * clk_mhz - 2;

	// one counter serves every phase, sized for the longest one
	localparam int cnt_max = (powerup_cycles > init_end) ? powerup_cycles : init_end;
	localparam int cnt_w   = $clog2(cnt_max + 1);

	typedef enum logic [1:0] {
		st_powerup,
		st_init,
		st_ready,
		st_write
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;
	lcd_cmd_t         cmd_q;      // command of the running write cycle
	logic [7:0]       init_data;  // init command selected by the counter
	logic             init_e;
	logic             write_e;

	// state and shared counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_powerup;
			cnt   <= '0;
		end else begin
			case (state)
				st_powerup: begin
					if (cnt == cnt_w'(powerup_cycles - 1)) begin
						state <= st_init;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_init: begin
					if (cnt == cnt_w'(init_end - 1)) begin // last entry-mode wait cycle
						state <= st_ready;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_ready: begin
					if (lcd_enable) begin
						state <= st_write;
						cnt   <= '0;
					end
				end
				st_write: begin
					if (cnt == cnt_w'(write_last)) begin
						state <= st_ready;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= st_powerup;
					cnt   <= '0;
				end
			endcase
		end
	end

	// command register, loaded only when a request is accepted
	always_ff @(posedge clk) begin
		if (state == st_ready && lcd_enable) begin
			cmd_q <= lcd_bus;
		end
	end

	// init command and enable from the counter window
	// data stays on the bus through the wait so it is stable at the e fall
	always_comb begin
		if (cnt < cnt_w'(fs_end)) begin
			init_data = {4'b0011, cfg.two_lines, cfg.font_5x10, 2'b00}; // function set, 8-bit
		end else if (cnt < cnt_w'(dc_end)) begin
			init_data = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.cursor_blink};
		end else if (cnt < cnt_w'(clr_end)) begin
			init_data = 8'h01; // clear display
		end else begin
			init_data = {6'b000001, cfg.addr_inc, cfg.display_shift};
		end

		init_e = (cnt < cnt_w'(fs_e_end))
			|| (cnt >= cnt_w'(fs_end) && cnt < cnt_w'(dc_e_end))
			|| (cnt >= cnt_w'(dc_end) && cnt < cnt_w'(clr_e_end))
			|| (cnt >= cnt_w'(clr_end) && cnt < cnt_w'(em_e_end));
	end

	// e pulse of a write cycle, after the setup time
	assign write_e = (cnt >= cnt_w'(setup_cycles)) && (cnt < cnt_w'(e_high_end));

	// pin and busy decode
	always_comb begin
		pins = '0;
		busy = 1'b1;
		case (state)
			st_init: begin
				pins.e    = init_e;
				pins.data = init_data; // rs and rw stay low, all instructions
			end
			st_ready: begin
				busy = 1'b0;
			end
			st_write: begin
				pins.e    = write_e;
				pins.rs   = cmd_q.rs;
				pins.rw   = cmd_q.rw;
				pins.data = cmd_q.data;
			end
			default: begin
				pins = '0; // power-up, pins idle
			end
		endcase
	end

endmodule

/* lcd_display.f */
lcd_pkg.sv
lcd_controller.sv
lcd_text_writer.sv
lcd_display_top.sv
lcd_bus_monitor.sv
lcd_tb.sv

/* lcd_display_top.sv */
module lcd_display_top
	import lcd_pkg::*;
#(
	parameter int  clk_mhz  = 20, // clock cycles per microsecond
	parameter int  line_len = 16, // characters per line
	localparam int addr_w   = $clog2(line_len)
) (
	input  logic              clk,
	input  logic              arst_n,
	input  lcd_cfg_t          cfg,
	input  logic              char_we,
	input  logic [addr_w-1:0] char_addr,
	input  logic [7:0]        char_data,
	input  logic              show,
	input  logic              row,
	output lcd_pins_t         pins,
	output logic              busy,
	output logic              sending
);

	logic     lcd_enable; // write request, writer to controller
	lcd_cmd_t lcd_bus;

	lcd_text_writer #(
		.line_len(line_len)
	) u_writer (
		.clk       (clk),
		.arst_n    (arst_n),
		.char_we   (char_we),
		.char_addr (char_addr),
		.char_data (char_data),
		.show      (show),
		.row       (row),
		.busy      (busy),
		.lcd_enable(lcd_enable),
		.lcd_bus   (lcd_bus),
		.sending   (sending)
	);

	lcd_controller #(
		.clk_mhz(clk_mhz)
	) u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg       (cfg),
		.lcd_enable(lcd_enable),
		.lcd_bus   (lcd_bus),
		.pins      (pins),
		.busy      (busy)
	);

endmodule

/* lcd_pkg.sv */
package lcd_pkg;

	// one transfer on the lcd bus
	// field order matches the 10-bit bus word, rs at the top
	typedef struct packed {
		logic       rs;   // 0 instruction, 1 data register
		logic       rw;   // 0 write, 1 read
		logic [7:0] data;
	} lcd_cmd_t;

	// display configuration used by the init sequence
	typedef struct packed {
		logic two_lines;     // N bit of function set
		logic font_5x10;     // F bit of function set
		logic display_on;    // D bit of display control
		logic cursor_on;     // C bit of display control
		logic cursor_blink;  // B bit of display control
		logic addr_inc;      // I/D bit of entry mode
		logic display_shift; // S bit of entry mode
	} lcd_cfg_t;

	// pins of an HD44780 module in 8-bit mode
	typedef struct packed {
		logic       e;    // enable, data latched on its falling edge
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	// power-up and init timing, microseconds
	localparam int t_powerup_us    = 500; // wait after supply rise
	localparam int t_cmd_us        = 10;  // e high for one init command
	localparam int t_wait_short_us = 50;  // after function set and display control
	localparam int t_wait_clear_us = 200; // clear display is the slow one
	localparam int t_wait_entry_us = 100; // after entry mode set

	// normal write cycle timing, microseconds
	localparam int t_setup_us      = 1;   // rs/data stable before e rises
	localparam int t_e_high_us     = 13;  // enable pulse width
	localparam int t_cycle_us      = 50;  // whole cycle, covers execution time

	// instruction codes
	localparam logic [7:0] cmd_set_ddram = 8'h80; // set ddram address, low bits = address
	localparam logic [7:0] row1_offset   = 8'h40; // ddram start of the second line

endpackage

/* lcd_tb.sv */
module lcd_tb
	import lcd_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_mhz  = 2;
	localparam int line_len = 16;
	localparam int addr_w   = $clog2(line_len);

	// cycle counts of the bus at 2 clocks per microsecond
	localparam int init_e_cycles   = 20;   // e high for one init command
	localparam int write_e_cycles  = 26;   // e high in a write cycle
	localparam int min_rise_gap    = 100;  // shortest spacing of e rises in writes
	localparam int busy_fall_cycle = 1880; // end of init after reset release

	// two lines, display and cursor on, no blink, increment
	localparam lcd_cfg_t cfg_a = 7'b1011010;
	// one line, 5x10 font, cursor off, blink, decrement with shift
	localparam lcd_cfg_t cfg_b = 7'b0110101;

	logic              clk;
	logic              arst_n;
	lcd_cfg_t          cfg;
	logic              char_we;
	logic [addr_w-1:0] char_addr;
	logic [7:0]        char_data;
	logic              show;
	logic              row;
	lcd_pins_t         pins;
	logic              busy;
	logic              sending;

	logic [31:0] lfsr = 32'h68af;
	logic [7:0]  line_chars [line_len]; // text now held in the line buffer
	int          n_checks = 0;
	int          n_errors = 0;
	int          n_tests  = 0;

	lcd_display_top #(
		.clk_mhz (clk_mhz),
		.line_len(line_len)
	) dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.cfg      (cfg),
		.char_we  (char_we),
		.char_addr(char_addr),
		.char_data(char_data),
		.show     (show),
		.row      (row),
		.pins     (pins),
		.busy     (busy),
		.sending  (sending)
	);

	lcd_bus_monitor mon (
		.clk (clk),
		.pins(pins)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [7:0] random_char();
		logic [6:0] v;
		v = '0;
		for (int b = 0; b < 7; b++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[5:0], lfsr[0]};
		end
		return 8'h20 + {1'b0, v % 7'd95}; // printable 0x20 to 0x7e
	endfunction

	// init instruction i from its base code and flag bit positions
	function automatic lcd_cmd_t init_cmd(input int i, input lcd_cfg_t c);
		lcd_cmd_t cmd;
		cmd.rs = 1'b0;
		cmd.rw = 1'b0;
		case (i)
			0:       cmd.data = 8'h30 | (8'(c.two_lines) << 3) | (8'(c.font_5x10) << 2);
			1:       cmd.data = 8'h08 | (8'(c.display_on) << 2) | (8'(c.cursor_on) << 1)
				| 8'(c.cursor_blink);
			2:       cmd.data = 8'h01;
			default: cmd.data = 8'h04 | (8'(c.addr_inc) << 1) | 8'(c.display_shift);
		endcase
		return cmd;
	endfunction

	task automatic check_cmd(input string name, input lcd_cmd_t got, input lcd_cmd_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		n_checks++;
		if (got != exp) begin
			$display("** Error: %s got %0h expected %0h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		n_errors++;
	endtask

	task automatic finish_test(input string name, input int err0);
		n_tests++;
		$display("%s: %s, %0d errors", name, (n_errors == err0) ? "ok" : "failed",
			n_errors - err0);
	endtask

	task automatic wait_busy_low(input int limit, output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (busy && cycles < limit);
		if (busy) report_timeout($sformatf("busy still high after %0d cycles", limit));
	endtask

	task automatic wait_sending_low(input int limit);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (sending && cycles < limit);
		if (sending) report_timeout($sformatf("sending still high after %0d cycles", limit));
	endtask

	task automatic wait_cmd_count(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (mon.cmd_q.size() < target && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (mon.cmd_q.size() < target) begin
			report_timeout($sformatf("display saw fewer than %0d commands", target));
		end
	endtask

	task automatic apply_reset(input lcd_cfg_t c);
		@(posedge clk);
		cfg    <= c;
		arst_n <= 1'b0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	task automatic fill_line();
		for (int i = 0; i < line_len; i++) begin
			line_chars[i] = random_char();
			@(posedge clk);
			char_we   <= 1'b1;
			char_addr <= addr_w'(i);
			char_data <= line_chars[i];
		end
		@(posedge clk);
		char_we <= 1'b0;
	endtask

	task automatic send_show(input logic r);
		@(posedge clk);
		show <= 1'b1;
		row  <= r;
		@(posedge clk);
		show <= 1'b0;
	endtask

	// address command followed by the line in order
	task automatic check_line_cmds(input int base, input logic r);
		lcd_cmd_t exp;
		check_count("commands per show", mon.cmd_q.size() - base, line_len + 1);
		exp.rs   = 1'b0;
		exp.rw   = 1'b0;
		exp.data = r ? 8'hc0 : 8'h80;
		if (mon.cmd_q.size() > base) check_cmd("ddram address cmd", mon.cmd_q[base], exp);
		for (int i = 0; i < line_len && base + 1 + i < mon.cmd_q.size(); i++) begin
			exp.rs   = 1'b1;
			exp.data = line_chars[i];
			check_cmd($sformatf("char cmd[%0d]", i), mon.cmd_q[base + 1 + i], exp);
		end
	endtask

	task automatic test_powerup_init(input string name, input lcd_cfg_t c);
		int   err0;
		int   base;
		int   cyc;
		int   extra;
		logic saw_e;
		logic saw_ready;
		err0      = n_errors;
		base      = mon.cmd_q.size();
		cyc       = 0;
		saw_e     = 1'b0;
		saw_ready = 1'b0;
		apply_reset(c);
		repeat (1000) begin
			@(negedge clk);
			cyc++;
			saw_e     |= pins.e;
			saw_ready |= !busy;
		end
		check_bit("pins.e during power-up", saw_e, 1'b0);
		check_bit("busy low during power-up", saw_ready, 1'b0);
		wait_busy_low(2000, extra);
		cyc = cyc + extra - 1; // first negedge still belongs to the release cycle
		if (cyc < busy_fall_cycle - 1 || cyc > busy_fall_cycle + 1) begin
			check_count("busy fall cycle", cyc, busy_fall_cycle);
		end else begin
			n_checks++;
		end
		check_count("init command count", mon.cmd_q.size() - base, 4);
		for (int i = 0; i < 4 && base + i < mon.cmd_q.size(); i++) begin
			check_cmd($sformatf("init cmd[%0d]", i), mon.cmd_q[base + i], init_cmd(i, c));
			check_count($sformatf("init e width[%0d]", i), mon.width_q[base + i],
				init_e_cycles);
		end
		finish_test(name, err0);
	endtask

	task automatic test_line(input string name, input logic r, output int base);
		int err0;
		int cycles;
		err0 = n_errors;
		fill_line();
		base = mon.cmd_q.size();
		send_show(r);
		@(negedge clk);
		check_bit("sending", sending, 1'b1);
		wait_sending_low(3000);
		wait_busy_low(200, cycles); // last write still on the pins
		check_line_cmds(base, r);
		finish_test(name, err0);
	endtask

	task automatic test_write_shape(input string name, input int base, input logic r);
		int       err0;
		int       idx;
		lcd_cmd_t exp;
		err0   = n_errors;
		exp.rw = 1'b0;
		for (int i = 0; i <= line_len && base + i < mon.cmd_q.size(); i++) begin
			idx = base + i;
			if (i == 0) begin
				exp.rs   = 1'b0;
				exp.data = r ? 8'hc0 : 8'h80;
			end else begin
				exp.rs   = 1'b1;
				exp.data = line_chars[i - 1];
			end
			check_count($sformatf("e width[%0d]", i), mon.width_q[idx], write_e_cycles);
			check_cmd($sformatf("pins at e rise[%0d]", i), mon.rise_cmd_q[idx], exp);
			if (i > 0) begin
				if (mon.gap_q[idx] < min_rise_gap) begin
					check_count($sformatf("e rise spacing[%0d]", i), mon.gap_q[idx],
						min_rise_gap);
				end else begin
					n_checks++;
				end
			end
		end
		finish_test(name, err0);
	endtask

	task automatic test_show_while_sending(input string name);
		int   err0;
		int   base;
		int   cycles;
		logic saw_sending;
		err0        = n_errors;
		base        = mon.cmd_q.size();
		saw_sending = 1'b0;
		send_show(1'b0);
		wait_cmd_count(base + 3, 1000);
		send_show(1'b1); // lands mid-transfer
		wait_sending_low(3000);
		wait_busy_low(200, cycles);
		repeat (300) begin
			@(negedge clk);
			saw_sending |= sending;
		end
		check_bit("sending after transfer", saw_sending, 1'b0);
		check_line_cmds(base, 1'b0);
		finish_test(name, err0);
	endtask

	initial begin
		int base;
		arst_n    <= 1'b0;
		cfg       <= cfg_a;
		char_we   <= 1'b0;
		char_addr <= '0;
		char_data <= '0;
		show      <= 1'b0;
		row       <= 1'b0;

		test_powerup_init("power-up and init", cfg_a);
		test_line("line 0 text", 1'b0, base);
		test_write_shape("write cycle shape", base, 1'b0);
		test_line("line 1 text", 1'b1, base);
		test_show_while_sending("show while sending");
		test_powerup_init("second configuration", cfg_b);

		$display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* lcd_text_writer.sv */
module lcd_text_writer
	import lcd_pkg::*;
#(
	parameter int  line_len = 16,
	localparam int addr_w   = $clog2(line_len)
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              char_we,
	input  logic [addr_w-1:0] char_addr,
	input  logic [7:0]        char_data,
	input  logic              show,
	input  logic              row,
	input  logic              busy,
	output logic              lcd_enable,
	output lcd_cmd_t          lcd_bus,
	output logic              sending
);

	// the command in lcd_bus is offered in issue and held in gap
	// until the controller has finished with it
	typedef enum logic [1:0] {
		st_idle,
		st_issue,
		st_gap
	} state_t;

	state_t            state;
	logic [addr_w-1:0] idx;                   // character being sent
	logic [7:0]        line_buf [line_len];   // one line of text
	logic [7:0]        ddram_cmd;             // address command for the selected row

	// host writes into the line buffer, locked while a line goes out
	always_ff @(posedge clk) begin
		if (char_we && !sending) begin
			line_buf[char_addr] <= char_data;
		end
	end

	// first ddram address of line 0 or line 1
	assign ddram_cmd = row ? (cmd_set_ddram + row1_offset) : cmd_set_ddram;

	// sequencer
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			idx   <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (show) begin
						state <= st_issue;
						idx   <= '0;
					end
				end
				st_issue: begin
					if (!busy) begin // controller takes the command this cycle
						if (!lcd_bus.rs) begin
							state <= st_gap; // address done, characters follow
						end else if (idx == addr_w'(line_len - 1)) begin
							state <= st_idle; // last character accepted
						end else begin
							idx   <= idx + 1'b1;
							state <= st_gap;
						end
					end
				end
				st_gap: begin
					if (!busy) begin
						state <= st_issue; // previous write finished
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// command register, changes only between writes
	always_ff @(posedge clk) begin
		if (state == st_idle && show) begin
			lcd_bus.rs   <= 1'b0;
			lcd_bus.rw   <= 1'b0;
			lcd_bus.data <= ddram_cmd;
		end else if (state == st_gap && !busy) begin
			lcd_bus.rs   <= 1'b1; // character to ddram
			lcd_bus.rw   <= 1'b0;
			lcd_bus.data <= line_buf[idx];
		end
	end

	// strobe only when the controller is free, so every strobe is taken
	assign lcd_enable = (state == st_issue) && !busy;

	// high from the cycle after show until the last character is taken
	assign sending = (state != st_idle);

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the lcd testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps --top-module lcd_tb \
	-f lcd_display.f -o lcd_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/lcd_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^No errors$" sim.log; then
	exit 0
fi
echo "simulation reported failures"
exit 1
